// File: hdl/scc_cfg.svh
`ifndef SCC_CFG_SVH
`define SCC_CFG_SVH

// build-wide constants for the scc

// width of the cpu bus and of every register
`define SCC_BYTE_W 8

// clk cycles per serial bit cell
// short value keeps simulation fast
// the board build ran at 282
`define SCC_BAUD_DIV 16

// WR15 after a force reset or hardware reset
// dcd, cts and the other status enables all on
`define SCC_WR15_RST 8'hf8

`endif

// File: hdl/scc_reg_pkg.sv
`include "scc_cfg.svh"

// register-side types shared by the bus decoder and the channel logic
package scc_reg_pkg;

	// register pointer loaded through WR0
	// bit 3 is the point-high flag
	typedef logic [3:0] rindex_t;

	// stored configuration of one channel
	typedef struct packed {
		// ext enable in bit 0 and tx enable in bit 1
		// rx interrupt mode in bits 4..3
		logic [`SCC_BYTE_W-1:0] wr1;
		// receiver enable in bit 0
		logic [`SCC_BYTE_W-1:0] wr3;
		// transmitter enable in bit 3
		logic [`SCC_BYTE_W-1:0] wr5;
		// dcd enable in bit 3 and cts enable in bit 5
		logic [`SCC_BYTE_W-1:0] wr15;
	} chan_cfg_t;

	// one-cycle strobes decoded from cpu accesses
	typedef struct packed {
		// WR0 command 010 per channel
		logic rst_ext_a;
		logic rst_ext_b;
		// WR0 command 101
		logic rst_tx_ip;
		// WR0 command 100
		logic rx_first_en;
		// data port accesses on channel A
		logic tx_wr_a;
		logic rx_rd_a;
		// WR9 channel resets, also raised by force reset
		logic reset_a;
		logic reset_b;
		// WR9 11 or hardware reset
		logic reset_force;
	} cmd_t;

endpackage

// File: hdl/scc_irq_pkg.sv
// interrupt-side types shared by the interrupt logic and the read map
package scc_irq_pkg;

	// pending sources, channel B has only external status
	typedef struct packed {
		logic rx_a;
		logic tx_a;
		logic ex_a;
		logic ex_b;
	} irq_pend_t;

	// vector status codes as the 8530 encodes them
	typedef enum logic [2:0] {
		vec_ex_b = 3'b001,
		vec_none = 3'b011,
		vec_tx_a = 3'b100,
		vec_ex_a = 3'b101,
		vec_rx_a = 3'b110
	} vec_stat_t;

	// status high, bits 6..4 hold the status reversed
	typedef struct packed {
		logic       wr2_hi;
		logic [2:0] stat_rev;
		logic [3:0] wr2_lo;
	} rr2_stat_hi_t;

	// status low, bits 3..1 in natural order
	typedef struct packed {
		logic [3:0] wr2_hi;
		logic [2:0] stat;
		logic       wr2_lo;
	} rr2_stat_lo_t;

	// RR2 on channel B, view picked by WR9 bit 4
	typedef union packed {
		rr2_stat_hi_t st_hi;
		rr2_stat_lo_t st_lo;
	} rr2_view_u;

endpackage

// File: hdl/scc_ext_status.sv
`timescale 1ns/1ps

module scc_ext_status #(
	parameter bit HAS_CTS = 1'b1
) (
	input  logic                   clk,
	input  logic                   reset_hw,
	input  logic                   i_dcd,
	input  logic                   i_cts,
	input  scc_reg_pkg::chan_cfg_t i_cfg,
	input  logic                   i_reset_ext,
	input  logic                   i_force_reset,
	output logic [1:0]             o_rr0_ext,
	output logic                   o_ex_ip
);
	logic cts_in;
	logic latch_open;
	logic dcd_lat;
	logic cts_lat;
	logic dcd_chg;
	logic cts_chg;
	logic do_latch;

	// channel B has no cts pin
	assign cts_in = HAS_CTS ? i_cts : 1'b0;

	// a change counts only when WR15 enables that input
	assign dcd_chg  = i_cfg.wr15[3] & (i_dcd != dcd_lat);
	assign cts_chg  = i_cfg.wr15[5] & (cts_in != cts_lat);
	assign do_latch = latch_open & (dcd_chg | cts_chg);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			o_ex_ip    <= 1'b0;
			dcd_lat    <= 1'b0;
			cts_lat    <= 1'b0;
		end else if (i_force_reset) begin
			latch_open <= 1'b1;
			o_ex_ip    <= 1'b0;
			dcd_lat    <= 1'b0;
			cts_lat    <= 1'b0;
		end else if (i_reset_ext) begin
			// reset ext/status reopens the latch
			latch_open <= 1'b1;
			o_ex_ip    <= 1'b0;
		end else if (do_latch) begin
			latch_open <= 1'b0;
			dcd_lat    <= i_dcd;
			cts_lat    <= cts_in;
			if (i_cfg.wr1[0])
				o_ex_ip <= 1'b1;
		end
	end

	// latched level for enabled inputs, live level otherwise
	assign o_rr0_ext = {i_cfg.wr15[5] ? cts_lat : cts_in, i_cfg.wr15[3] ? dcd_lat : i_dcd};

endmodule

// File: hdl/scc_int_ctrl.sv
`timescale 1ns/1ps

module scc_int_ctrl (
	input  logic                   clk,
	input  logic                   reset_hw,
	input  scc_reg_pkg::cmd_t      i_cmd,
	input  scc_reg_pkg::chan_cfg_t i_cfg_a,
	input  logic                   i_mie,
	input  logic                   i_rx_strobe,
	input  logic                   i_tx_busy,
	input  logic                   i_ex_ip_a,
	input  logic                   i_ex_ip_b,
	output scc_irq_pkg::irq_pend_t o_pend,
	output scc_irq_pkg::vec_stat_t o_vec,
	output logic                   o_rx_avail,
	output logic                   o_irq_n
);
	logic rx_first;
	logic busy_q;
	logic tx_ip;
	logic tx_done;
	logic rx_mode_ok;
	logic rx_ip;

	// character waiting and first-character arming
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_rx_avail <= 1'b0;
			rx_first   <= 1'b1;
		end else if (i_cmd.reset_a) begin
			o_rx_avail <= 1'b0;
			rx_first   <= 1'b1;
		end else begin
			if (i_cmd.rx_rd_a) begin
				o_rx_avail <= 1'b0;
				rx_first   <= 1'b0;
			end
			// a new character wins over a read in the same cycle
			if (i_rx_strobe)
				o_rx_avail <= 1'b1;
			if (i_cmd.rx_first_en)
				rx_first <= 1'b1;
		end
	end

	// tx interrupt fires when the transmitter goes idle
	assign tx_done = busy_q & ~i_tx_busy;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			busy_q <= 1'b0;
			tx_ip  <= 1'b0;
		end else begin
			busy_q <= i_tx_busy;
			if (i_cmd.reset_a || i_cmd.tx_wr_a || i_cmd.rst_tx_ip || !i_cfg_a.wr5[3])
				tx_ip <= 1'b0;
			else if (tx_done && i_cfg_a.wr1[1])
				tx_ip <= 1'b1;
		end
	end

	// WR1 mode 01 is first character only, 10 is every character
	assign rx_mode_ok = (i_cfg_a.wr1[4:3] == 2'b01 && rx_first) || i_cfg_a.wr1[4:3] == 2'b10;
	assign rx_ip      = i_cfg_a.wr3[0] & o_rx_avail & rx_mode_ok;

	assign o_pend = '{rx_a: rx_ip, tx_a: tx_ip, ex_a: i_ex_ip_a, ex_b: i_ex_ip_b};

	// highest priority source names the vector
	always_comb begin
		if (rx_ip)
			o_vec = scc_irq_pkg::vec_rx_a;
		else if (tx_ip)
			o_vec = scc_irq_pkg::vec_tx_a;
		else if (i_ex_ip_a)
			o_vec = scc_irq_pkg::vec_ex_a;
		else if (i_ex_ip_b)
			o_vec = scc_irq_pkg::vec_ex_b;
		else
			o_vec = scc_irq_pkg::vec_none;
	end

	assign o_irq_n = ~(i_mie & (rx_ip | tx_ip | i_ex_ip_a | i_ex_ip_b));

endmodule

// File: hdl/scc_uart_rx.sv
`timescale 1ns/1ps
`include "scc_cfg.svh"

module scc_uart_rx (
	input  logic                   clk,
	input  logic                   reset_hw,
	input  logic                   i_reset_chan,
	input  logic                   i_rxd,
	output logic                   o_strobe,
	output logic [`SCC_BYTE_W-1:0] o_data
);
	localparam int CELL_W = $clog2(`SCC_BAUD_DIV);
	localparam int CNT_W  = $clog2(`SCC_BYTE_W + 2);
	localparam logic [CELL_W-1:0] CELL_LAST = CELL_W'(`SCC_BAUD_DIV - 1);
	localparam logic [CELL_W-1:0] CELL_HALF = CELL_W'(`SCC_BAUD_DIV / 2 - 1);
	localparam logic [CNT_W-1:0]  BIT_STOP  = CNT_W'(`SCC_BYTE_W + 1);

	logic [2:0]             rxd_sync;
	logic                   rx_bit;
	logic                   start_edge;
	logic                   busy;
	logic                   sample;
	logic [CELL_W-1:0]      cell_cnt;
	logic [CNT_W-1:0]       bit_cnt;
	logic [`SCC_BYTE_W-1:0] shreg;

	// two stages against metastability, third one for the edge
	assign rx_bit     = rxd_sync[1];
	assign start_edge = rxd_sync[2] & ~rxd_sync[1];
	assign sample     = busy & (cell_cnt == '0);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_sync <= '1;
			busy     <= 1'b0;
			cell_cnt <= '0;
			bit_cnt  <= '0;
			o_strobe <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[1:0], i_rxd};
			o_strobe <= 1'b0;
			if (i_reset_chan) begin
				busy <= 1'b0;
			end else if (!busy) begin
				// half a cell to reach the middle of the start bit
				if (start_edge) begin
					busy     <= 1'b1;
					cell_cnt <= CELL_HALF;
					bit_cnt  <= '0;
				end
			end else if (cell_cnt != '0) begin
				cell_cnt <= cell_cnt - 1'b1;
			end else begin
				cell_cnt <= CELL_LAST;
				bit_cnt  <= bit_cnt + 1'b1;
				// start bit gone high again means a glitch
				if (bit_cnt == '0 && rx_bit) begin
					busy <= 1'b0;
				end else if (bit_cnt == BIT_STOP) begin
					busy     <= 1'b0;
					o_strobe <= 1'b1;
				end
			end
		end
	end

	// lsb arrives first, the start bit falls out the bottom
	always_ff @(posedge clk) begin
		if (sample)
			shreg <= {rx_bit, shreg[`SCC_BYTE_W-1:1]};
		if (sample && bit_cnt == BIT_STOP)
			o_data <= shreg;
	end

endmodule

// File: hdl/scc_uart_tx.sv
`timescale 1ns/1ps
`include "scc_cfg.svh"

module scc_uart_tx (
	input  logic                   clk,
	input  logic                   reset_hw,
	input  logic                   i_reset_chan,
	input  logic                   i_wr,
	input  logic [`SCC_BYTE_W-1:0] i_data,
	output logic                   o_txd,
	output logic                   o_busy
);
	localparam int FRAME_W = `SCC_BYTE_W + 2;
	localparam int CELL_W  = $clog2(`SCC_BAUD_DIV);
	localparam int CNT_W   = $clog2(FRAME_W);
	localparam logic [CELL_W-1:0] CELL_LAST = CELL_W'(`SCC_BAUD_DIV - 1);
	localparam logic [CNT_W-1:0]  BIT_LAST  = CNT_W'(FRAME_W - 1);

	// stop, data and start bits, line driven from bit 0
	logic [FRAME_W-1:0] frame;
	logic [CELL_W-1:0]  cell_cnt;
	logic [CNT_W-1:0]   bit_cnt;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			frame    <= '1;
			cell_cnt <= '0;
			bit_cnt  <= '0;
			o_busy   <= 1'b0;
		end else if (i_reset_chan) begin
			frame    <= '1;
			cell_cnt <= '0;
			bit_cnt  <= '0;
			o_busy   <= 1'b0;
		end else if (!o_busy) begin
			// writes during a frame are lost
			if (i_wr) begin
				frame    <= {1'b1, i_data, 1'b0};
				cell_cnt <= '0;
				bit_cnt  <= '0;
				o_busy   <= 1'b1;
			end
		end else if (cell_cnt == CELL_LAST) begin
			cell_cnt <= '0;
			// idle level shifts in behind the frame
			frame    <= {1'b1, frame[FRAME_W-1:1]};
			if (bit_cnt == BIT_LAST)
				o_busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			cell_cnt <= cell_cnt + 1'b1;
		end
	end

	assign o_txd = frame[0];

endmodule

// File: hdl/scc_bus_regs.sv
`timescale 1ns/1ps
`include "scc_cfg.svh"

module scc_bus_regs (
	input  logic                      clk,
	input  logic                      reset_hw,
	input  logic                      i_cs,
	input  logic                      i_we,
	input  logic [1:0]                i_rs,
	input  logic [`SCC_BYTE_W-1:0]    i_wdata,
	input  logic [`SCC_BYTE_W-1:0]    i_rx_data,
	input  logic                      i_rx_avail,
	input  logic                      i_tx_busy,
	input  scc_irq_pkg::irq_pend_t    i_pend,
	input  scc_irq_pkg::vec_stat_t    i_vec,
	input  logic [1:0]                i_rr0_ext_a,
	input  logic [1:0]                i_rr0_ext_b,
	output logic [`SCC_BYTE_W-1:0]    o_rdata,
	output scc_reg_pkg::cmd_t         o_cmd,
	output scc_reg_pkg::chan_cfg_t    o_cfg_a,
	output scc_reg_pkg::chan_cfg_t    o_cfg_b,
	output logic [`SCC_BYTE_W-1:0]    o_tx_data,
	output logic                      o_mie
);
	localparam int BW = `SCC_BYTE_W;
	// bits kept through a channel reset
	localparam logic [BW-1:0] WR1_KEEP = 'h24;
	localparam logic [BW-1:0] WR5_KEEP = 'h61;
	// RR15 hides bits 2 and 0
	localparam logic [BW-1:0] RR15_MASK = 'hfa;

	// pointer seen by the bus, and the value it takes once cs drops
	scc_reg_pkg::rindex_t   rindex;
	scc_reg_pkg::rindex_t   rindex_nxt;
	// per-channel registers, index 1 is A and 0 is B like i_rs[0]
	scc_reg_pkg::chan_cfg_t cfg_q [2];
	logic [BW-1:0]          wr12_q [2];
	logic [BW-1:0]          wr13_q [2];
	logic [BW-1:0]          wr2_q;
	logic                   wr9_mie;
	logic                   wr9_vis;
	logic                   ctl_acc;
	logic                   ctl_wr;
	logic                   wr0_wr;
	logic                   wr9_wr;
	logic [2:0]             wr0_cmd;
	logic [1:0]             wreg;
	logic [1:0]             chan_rst;
	logic [BW-1:0]          rr0 [2];
	logic [BW-1:0]          rr1 [2];
	logic [BW-1:0]          rr3_a;
	scc_irq_pkg::rr2_view_u rr2_b;

	assign ctl_acc = i_cs & ~i_rs[1];
	assign ctl_wr  = ctl_acc & i_we;
	assign wr0_wr  = ctl_wr & (rindex == 4'd0);
	assign wr9_wr  = ctl_wr & (rindex == 4'd9);
	assign wr0_cmd = i_wdata[5:3];
	assign wreg    = {ctl_wr & i_rs[0], ctl_wr & ~i_rs[0]};

	// command strobes, valid during the bus cycle itself
	always_comb begin
		o_cmd.rst_ext_a   = wr0_wr & i_rs[0] & (wr0_cmd == 3'b010);
		o_cmd.rst_ext_b   = wr0_wr & ~i_rs[0] & (wr0_cmd == 3'b010);
		o_cmd.rst_tx_ip   = wr0_wr & i_rs[0] & (wr0_cmd == 3'b101);
		o_cmd.rx_first_en = wr0_wr & i_rs[0] & (wr0_cmd == 3'b100);
		o_cmd.tx_wr_a     = i_cs & i_we & (i_rs == 2'b11);
		o_cmd.rx_rd_a     = i_cs & ~i_we & (i_rs == 2'b11);
		// WR9 bits 7..6 select the reset, either side may write it
		o_cmd.reset_force = reset_hw | (wr9_wr & (i_wdata[7:6] == 2'b11));
		o_cmd.reset_a     = o_cmd.reset_force | (wr9_wr & (i_wdata[7:6] == 2'b10));
		o_cmd.reset_b     = o_cmd.reset_force | (wr9_wr & (i_wdata[7:6] == 2'b01));
	end

	assign chan_rst = {o_cmd.reset_a, o_cmd.reset_b};

	// pointer moves only while cs is low so read data stays put
	// during the cpu cycle
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex     <= '0;
			rindex_nxt <= '0;
		end else begin
			if (!i_cs)
				rindex <= rindex_nxt;
			// WR0 loads the pointer, point high is command 001
			if (wr0_wr)
				rindex_nxt <= {wr0_cmd == 3'b001, i_wdata[2:0]};
			// any other control access falls back to WR0
			else if (ctl_acc)
				rindex_nxt <= '0;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			for (int ch = 0; ch < 2; ch++) begin
				cfg_q[ch]  <= '{wr1: '0, wr3: '0, wr5: '0, wr15: `SCC_WR15_RST};
				wr12_q[ch] <= '0;
				wr13_q[ch] <= '0;
			end
			wr2_q   <= '0;
			wr9_mie <= 1'b0;
			wr9_vis <= 1'b0;
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				if (chan_rst[ch]) begin
					cfg_q[ch].wr1 <= cfg_q[ch].wr1 & WR1_KEEP;
					cfg_q[ch].wr5 <= cfg_q[ch].wr5 & WR5_KEEP;
				end else if (wreg[ch]) begin
					case (rindex)
						4'd1:    cfg_q[ch].wr1  <= i_wdata;
						4'd3:    cfg_q[ch].wr3  <= i_wdata;
						4'd5:    cfg_q[ch].wr5  <= i_wdata;
						4'd12:   wr12_q[ch]     <= i_wdata;
						4'd13:   wr13_q[ch]     <= i_wdata;
						4'd15:   cfg_q[ch].wr15 <= i_wdata;
						default: ;
					endcase
				end
				if (o_cmd.reset_force)
					cfg_q[ch].wr15 <= `SCC_WR15_RST;
			end
			// WR2 and WR9 are shared by both channels
			if (ctl_wr && rindex == 4'd2)
				wr2_q <= i_wdata;
			if (wr9_wr) begin
				wr9_mie <= i_wdata[3];
				wr9_vis <= i_wdata[4];
			end
		end
	end

	// RR0 with tx underrun fixed at 1, B has no receiver or transmitter
	assign rr0[1] = {2'b01, i_rr0_ext_a[1], 1'b0, i_rr0_ext_a[0], ~i_tx_busy, 1'b0, i_rx_avail};
	assign rr0[0] = {2'b01, i_rr0_ext_b[1], 1'b0, i_rr0_ext_b[0], 3'b100};
	// residue code 011 and all sent
	assign rr1[1] = {7'h03, ~i_tx_busy};
	assign rr1[0] = 8'h07;
	assign rr3_a  = {2'b00, i_pend.rx_a, i_pend.tx_a, i_pend.ex_a, 2'b00, i_pend.ex_b};

	always_comb begin
		if (wr9_vis) begin
			rr2_b.st_hi.wr2_hi   = wr2_q[7];
			rr2_b.st_hi.stat_rev = {<<{i_vec}};
			rr2_b.st_hi.wr2_lo   = wr2_q[3:0];
		end else begin
			rr2_b.st_lo.wr2_hi = wr2_q[7:4];
			rr2_b.st_lo.stat   = i_vec;
			rr2_b.st_lo.wr2_lo = wr2_q[0];
		end
	end

	// read map with the 8530 aliasing
	always_comb begin
		o_rdata = '0;
		if (i_rs[1]) begin
			if (i_rs[0])
				o_rdata = i_rx_data;
		end else begin
			case (rindex)
				4'd0, 4'd4:   o_rdata = rr0[i_rs[0]];
				4'd1, 4'd5:   o_rdata = rr1[i_rs[0]];
				4'd2, 4'd6:   o_rdata = i_rs[0] ? wr2_q : rr2_b;
				4'd3, 4'd7:   o_rdata = i_rs[0] ? rr3_a : '0;
				4'd8:         o_rdata = i_rs[0] ? i_rx_data : '0;
				4'd9, 4'd13:  o_rdata = wr13_q[i_rs[0]];
				4'd11, 4'd15: o_rdata = cfg_q[i_rs[0]].wr15 & RR15_MASK;
				4'd12:        o_rdata = wr12_q[i_rs[0]];
				default:      o_rdata = '0;
			endcase
		end
	end

	assign o_cfg_a   = cfg_q[1];
	assign o_cfg_b   = cfg_q[0];
	// transmitter takes the byte on the write strobe
	assign o_tx_data = i_wdata;
	assign o_mie     = wr9_mie;

endmodule

// File: hdl/scc.sv
`timescale 1ns/1ps
`include "scc_cfg.svh"

module scc (
	input  logic                   clk,
	input  logic                   reset_hw,
	input  logic                   i_cs,
	input  logic                   i_we,
	input  logic [1:0]             i_rs,
	input  logic [`SCC_BYTE_W-1:0] i_wdata,
	input  logic                   i_rxd,
	input  logic                   i_cts,
	input  logic                   i_dcd_a,
	input  logic                   i_dcd_b,
	output logic [`SCC_BYTE_W-1:0] o_rdata,
	output logic                   o_irq_n,
	output logic                   o_txd,
	output logic                   o_rts
);
	scc_reg_pkg::cmd_t      cmd;
	scc_reg_pkg::chan_cfg_t cfg_a;
	scc_reg_pkg::chan_cfg_t cfg_b;
	scc_irq_pkg::irq_pend_t pend;
	scc_irq_pkg::vec_stat_t vec;
	logic [`SCC_BYTE_W-1:0] rx_data;
	logic [`SCC_BYTE_W-1:0] tx_data;
	logic [1:0]             rr0_ext_a;
	logic [1:0]             rr0_ext_b;
	logic                   rx_avail;
	logic                   rx_strobe;
	logic                   tx_busy;
	logic                   mie;
	logic                   ex_ip_a;
	logic                   ex_ip_b;

	scc_bus_regs u_bus_regs (
		.clk(clk), .reset_hw(reset_hw), .i_cs(i_cs), .i_we(i_we), .i_rs(i_rs),
		.i_wdata(i_wdata), .i_rx_data(rx_data), .i_rx_avail(rx_avail),
		.i_tx_busy(tx_busy), .i_pend(pend), .i_vec(vec),
		.i_rr0_ext_a(rr0_ext_a), .i_rr0_ext_b(rr0_ext_b), .o_rdata(o_rdata),
		.o_cmd(cmd), .o_cfg_a(cfg_a), .o_cfg_b(cfg_b), .o_tx_data(tx_data), .o_mie(mie)
	);

	scc_int_ctrl u_int_ctrl (
		.clk(clk), .reset_hw(reset_hw), .i_cmd(cmd), .i_cfg_a(cfg_a), .i_mie(mie),
		.i_rx_strobe(rx_strobe), .i_tx_busy(tx_busy), .i_ex_ip_a(ex_ip_a),
		.i_ex_ip_b(ex_ip_b), .o_pend(pend), .o_vec(vec), .o_rx_avail(rx_avail),
		.o_irq_n(o_irq_n)
	);

	scc_ext_status #(.HAS_CTS(1'b1)) ext_a (
		.clk(clk), .reset_hw(reset_hw), .i_dcd(i_dcd_a), .i_cts(i_cts), .i_cfg(cfg_a),
		.i_reset_ext(cmd.rst_ext_a), .i_force_reset(cmd.reset_force),
		.o_rr0_ext(rr0_ext_a), .o_ex_ip(ex_ip_a)
	);

	scc_ext_status #(.HAS_CTS(1'b0)) ext_b (
		.clk(clk), .reset_hw(reset_hw), .i_dcd(i_dcd_b), .i_cts(1'b0), .i_cfg(cfg_b),
		.i_reset_ext(cmd.rst_ext_b), .i_force_reset(cmd.reset_force),
		.o_rr0_ext(rr0_ext_b), .o_ex_ip(ex_ip_b)
	);

	scc_uart_rx u_uart_rx (
		.clk(clk), .reset_hw(reset_hw), .i_reset_chan(cmd.reset_a), .i_rxd(i_rxd),
		.o_strobe(rx_strobe), .o_data(rx_data)
	);

	scc_uart_tx u_uart_tx (
		.clk(clk), .reset_hw(reset_hw), .i_reset_chan(cmd.reset_a), .i_wr(cmd.tx_wr_a),
		.i_data(tx_data), .o_txd(o_txd), .o_busy(tx_busy)
	);

	// rts follows a waiting receive character
	assign o_rts = rx_avail;

endmodule

// File: verification/scc_tb.sv
`timescale 1ns/1ps
`include "scc_cfg.svh"

module scc_tb;
	localparam int FRAME_CYC = 10 * `SCC_BAUD_DIV;
	// six serial frames plus room for the register traffic
	localparam int TIMEOUT_CYC = 6 * FRAME_CYC + 2000;
	// i_rs bit 0 picks channel A
	localparam logic CH_A = 1'b1;
	localparam logic CH_B = 1'b0;

	logic                   clk;
	logic                   reset_hw;
	logic                   i_cs;
	logic                   i_we;
	logic [1:0]             i_rs;
	logic [`SCC_BYTE_W-1:0] i_wdata;
	logic                   i_rxd;
	logic                   i_cts;
	logic                   i_dcd_a;
	logic                   i_dcd_b;
	logic [`SCC_BYTE_W-1:0] o_rdata;
	logic                   o_irq_n;
	logic                   o_txd;
	logic                   o_rts;

	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] lcg_state;

	scc UUT (
		.clk(clk), .reset_hw(reset_hw), .i_cs(i_cs), .i_we(i_we), .i_rs(i_rs),
		.i_wdata(i_wdata), .i_rxd(i_rxd), .i_cts(i_cts), .i_dcd_a(i_dcd_a),
		.i_dcd_b(i_dcd_b), .o_rdata(o_rdata), .o_irq_n(o_irq_n), .o_txd(o_txd),
		.o_rts(o_rts)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog that ends a stuck run
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// next pseudo random byte
	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// WR0 value that points at a register where command 001 reaches 8..15
	function automatic logic [7:0] point_byte(input logic [3:0] idx);
		return {2'b00, idx[3] ? 3'b001 : 3'b000, idx[2:0]};
	endfunction

	// RR2 on B holds the status in 3..1 or reversed in 6..4 and WR2 elsewhere
	function automatic logic [7:0] rr2_expect(input logic [2:0] stat, input logic hi,
			input logic [7:0] wr2);
		logic [7:0] v;
		v = wr2;
		if (hi) begin
			v[6] = stat[0];
			v[5] = stat[1];
			v[4] = stat[2];
		end else begin
			v[3:1] = stat;
		end
		return v;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// one cpu access, then cs low across the next rising edge
	task automatic bus_cycle(input logic we, input logic [1:0] rs, input logic [7:0] wdata,
			output logic [7:0] rdata);
		@(negedge clk);
		i_cs    = 1'b1;
		i_we    = we;
		i_rs    = rs;
		i_wdata = wdata;
		// read data depends only on i_rs and the pointer
		#2;
		rdata = o_rdata;
		@(negedge clk);
		i_cs = 1'b0;
		i_we = 1'b0;
	endtask

	task automatic reg_write(input logic ch, input logic [3:0] idx, input logic [7:0] data);
		logic [7:0] dummy;
		if (idx != 4'd0)
			bus_cycle(1'b1, {1'b0, ch}, point_byte(idx), dummy);
		bus_cycle(1'b1, {1'b0, ch}, data, dummy);
	endtask

	task automatic reg_read(input logic ch, input logic [3:0] idx, output logic [7:0] data);
		logic [7:0] dummy;
		if (idx != 4'd0)
			bus_cycle(1'b1, {1'b0, ch}, point_byte(idx), dummy);
		bus_cycle(1'b0, {1'b0, ch}, 8'h00, data);
	endtask

	task automatic data_write(input logic [7:0] data);
		logic [7:0] dummy;
		bus_cycle(1'b1, 2'b11, data, dummy);
	endtask

	task automatic data_read(output logic [7:0] data);
		bus_cycle(1'b0, 2'b11, 8'h00, data);
	endtask

	// 8N1 frame on i_rxd with the lsb first
	task automatic send_frame(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			@(negedge clk);
			i_rxd = bits[b];
			repeat (`SCC_BAUD_DIV - 1) @(negedge clk);
		end
	endtask

	// called on the first falling edge after the data write
	task automatic expect_frame(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			repeat (`SCC_BAUD_DIV) begin
				check_bit("o_txd", o_txd, bits[b]);
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_rx_avail();
		logic [7:0] rr0;
		rr0 = 8'h00;
		while (rr0[0] !== 1'b1)
			reg_read(CH_A, 4'd0, rr0);
	endtask

	task automatic wait_irq();
		while (o_irq_n !== 1'b0)
			@(negedge clk);
	endtask

	task automatic test_reset();
		logic [7:0] rd;
		check_bit("o_irq_n", o_irq_n, 1'b1);
		check_bit("o_txd", o_txd, 1'b1);
		check_bit("o_rts", o_rts, 1'b0);
		reg_read(CH_A, 4'd15, rd);
		check_byte("rr15_a", rd, 8'hf8);
		reg_read(CH_A, 4'd1, rd);
		check_byte("rr1_a", rd, 8'h07);
		// tx empty and bit 6, dcd and cts low
		reg_read(CH_A, 4'd0, rd);
		check_byte("rr0_a", rd, 8'h44);
		reg_read(CH_A, 4'd3, rd);
		check_byte("rr3_a", rd, 8'h00);
	endtask

	task automatic test_pointer();
		logic [7:0] rd;
		reg_write(CH_A, 4'd12, 8'h5a);
		reg_write(CH_A, 4'd13, 8'ha5);
		reg_write(CH_B, 4'd12, 8'h3c);
		reg_write(CH_B, 4'd13, 8'hc3);
		reg_read(CH_A, 4'd12, rd);
		check_byte("wr12_a", rd, 8'h5a);
		reg_read(CH_A, 4'd13, rd);
		check_byte("wr13_a", rd, 8'ha5);
		// RR9 mirrors WR13
		reg_read(CH_A, 4'd9, rd);
		check_byte("rr9_a", rd, 8'ha5);
		reg_read(CH_B, 4'd12, rd);
		check_byte("wr12_b", rd, 8'h3c);
		reg_read(CH_B, 4'd13, rd);
		check_byte("wr13_b", rd, 8'hc3);
		reg_read(CH_B, 4'd9, rd);
		check_byte("rr9_b", rd, 8'hc3);
		// pointer is back at 0
		reg_read(CH_A, 4'd0, rd);
		check_byte("rr0_a", rd, 8'h44);
	endtask

	task automatic test_transmit();
		logic [7:0] tx_byte;
		logic [7:0] rd;
		tx_byte = lcg_byte();
		data_write(tx_byte);
		expect_frame(tx_byte);
		reg_read(CH_A, 4'd0, rd);
		check_bit("rr0_a[2]", rd[2], 1'b1);
		reg_read(CH_A, 4'd1, rd);
		check_bit("rr1_a[0]", rd[0], 1'b1);
	endtask

	task automatic test_receive();
		logic [7:0] rx_byte;
		logic [7:0] rd;
		rx_byte = lcg_byte();
		send_frame(rx_byte);
		wait_rx_avail();
		check_bit("o_rts", o_rts, 1'b1);
		data_read(rd);
		check_byte("rx_data", rd, rx_byte);
		check_bit("o_rts", o_rts, 1'b0);
		reg_read(CH_A, 4'd0, rd);
		check_bit("rr0_a[0]", rd[0], 1'b0);
	endtask

	task automatic test_rx_irq();
		logic [7:0] rx_byte;
		logic [7:0] rd;
		// interrupt on every character, receiver on, master enable
		reg_write(CH_A, 4'd1, 8'h10);
		reg_write(CH_A, 4'd3, 8'h01);
		reg_write(CH_A, 4'd9, 8'h08);
		check_bit("o_irq_n", o_irq_n, 1'b1);
		rx_byte = lcg_byte();
		send_frame(rx_byte);
		wait_irq();
		reg_read(CH_A, 4'd3, rd);
		check_byte("rr3_a", rd, 8'h20);
		// receive on A is status 110
		reg_read(CH_B, 4'd2, rd);
		check_byte("rr2_b", rd, rr2_expect(3'b110, 1'b0, 8'h00));
		reg_write(CH_A, 4'd9, 8'h18);
		reg_read(CH_B, 4'd2, rd);
		check_byte("rr2_b", rd, rr2_expect(3'b110, 1'b1, 8'h00));
		data_read(rd);
		check_byte("rx_data", rd, rx_byte);
		check_bit("o_irq_n", o_irq_n, 1'b1);
	endtask

	task automatic test_ext_b();
		logic [7:0] rd;
		// dcd enable only, ext interrupt on
		reg_write(CH_B, 4'd15, 8'h08);
		reg_write(CH_B, 4'd1, 8'h01);
		check_bit("o_irq_n", o_irq_n, 1'b1);
		@(negedge clk);
		i_dcd_b = 1'b1;
		wait_irq();
		reg_read(CH_A, 4'd3, rd);
		check_byte("rr3_a", rd, 8'h01);
		// closed latch keeps the captured high after dcd drops
		@(negedge clk);
		i_dcd_b = 1'b0;
		reg_read(CH_B, 4'd0, rd);
		check_bit("rr0_b[3]", rd[3], 1'b1);
		@(negedge clk);
		i_dcd_b = 1'b1;
		// reset ext/status while dcd still matches the latch
		reg_write(CH_B, 4'd0, 8'h10);
		check_bit("o_irq_n", o_irq_n, 1'b1);
	endtask

	initial begin
		reset_hw  = 1'b1;
		i_cs      = 1'b0;
		i_we      = 1'b0;
		i_rs      = 2'b00;
		i_wdata   = '0;
		i_rxd     = 1'b1;
		i_cts     = 1'b0;
		i_dcd_a   = 1'b0;
		i_dcd_b   = 1'b0;
		errors    = 0;
		checks    = 0;
		lcg_state = 32'h7526_2ac1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_hw = 1'b0;
		test_reset();
		test_pointer();
		test_transmit();
		test_receive();
		test_rx_irq();
		test_ext_b();
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
+incdir+hdl
hdl/scc_reg_pkg.sv
hdl/scc_irq_pkg.sv
hdl/scc_ext_status.sv
hdl/scc_int_ctrl.sv
hdl/scc_uart_rx.sv
hdl/scc_uart_tx.sv
hdl/scc_bus_regs.sv
hdl/scc.sv
verification/scc_tb.sv

// File: Makefile
TOP := scc_tb

.PHONY: all lint clean

# build the simulator, run it, and pass only when the pass line shows up
all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
